/* design/cache_params_pkg.sv */
package cache_params_pkg;

    // Data word and block geometry
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;

    // Address field widths, low to high
    localparam int BYTE_OFF_BIT_LEN  = 2;
    localparam int BLOCK_OFF_BIT_LEN = 2;
    localparam int INDEX_BIT_LEN     = 4;
    localparam int TAG_BIT_LEN       = 4;

    localparam int ADDR_W = TAG_BIT_LEN + INDEX_BIT_LEN + BLOCK_OFF_BIT_LEN + BYTE_OFF_BIT_LEN;

    // Block number is tag and index together
    localparam int BLOCK_ADDR_W = TAG_BIT_LEN + INDEX_BIT_LEN;
    localparam int NUM_BLOCKS   = 2 ** BLOCK_ADDR_W;

    localparam int UUID_W = 4;

    // MSHR queue depth, head is the top slot
    localparam int MSHR_BUFFER_LEN = 4;

    // Cycles the fill bank stays busy per entry
    localparam int FILL_LATENCY = 6;
    localparam int FILL_CNT_W   = $clog2(FILL_LATENCY);

endpackage

/* design/cache_types_pkg.sv */
package cache_types_pkg;

    import cache_params_pkg::*;

    // Field view of a byte address
    typedef struct packed {
        logic [TAG_BIT_LEN-1:0]       tag;
        logic [INDEX_BIT_LEN-1:0]     index;
        logic [BLOCK_OFF_BIT_LEN-1:0] block_offset;
        logic [BYTE_OFF_BIT_LEN-1:0]  byte_offset;
    } cache_addr_t;

    // Same address, read flat or by fields
    typedef union packed {
        logic [ADDR_W-1:0] word;
        cache_addr_t       fields;
    } cache_addr_u;

    // One outstanding miss with its merged stores
    typedef struct packed {
        logic                                    valid;
        logic [UUID_W-1:0]                       uuid;
        logic [ADDR_W-1:0]                       block_addr;
        logic [WORDS_PER_BLOCK-1:0]              write_status;
        logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0]  write_block;
    } mshr_reg;

endpackage

/* design/backing_store.sv */
`timescale 1ns/1ns

module backing_store import cache_params_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic [BLOCK_ADDR_W-1:0]                rd_block_addr,
    output logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] rd_block,
    input  logic                                   wr_en,
    input  logic [BLOCK_ADDR_W-1:0]                wr_block_addr,
    input  logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] wr_block
);

    // One whole block per location
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] mem [NUM_BLOCKS];

    // Asynchronous read
    assign rd_block = mem[rd_block_addr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int b = 0; b < NUM_BLOCKS; b++) begin
                mem[b] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_block_addr] <= wr_block;
        end
    end

endmodule

/* design/cache_mshr_buffer.sv */
`timescale 1ns/1ns

module cache_mshr_buffer import cache_params_pkg::*, cache_types_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   miss,
    input  logic [UUID_W-1:0]                      uuid,
    input  cache_addr_u                            addr,
    input  logic                                   rw_mode,
    input  logic [WORD_W-1:0]                      store_value,
    input  logic                                   bank_empty,
    output logic                                   stall,
    output logic                                   head_valid,
    output logic [UUID_W-1:0]                      head_uuid,
    output logic [ADDR_W-1:0]                      head_block_addr,
    output logic [WORDS_PER_BLOCK-1:0]             head_write_status,
    output logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] head_write_block
);

    localparam int HEAD = MSHR_BUFFER_LEN - 1;

    mshr_reg [MSHR_BUFFER_LEN-1:0] buffer;
    mshr_reg [MSHR_BUFFER_LEN-1:0] merged;
    mshr_reg [MSHR_BUFFER_LEN-1:0] next_buffer;
    mshr_reg                       new_entry;
    cache_addr_u                   blk;
    logic [MSHR_BUFFER_LEN-2:0]    hit;
    logic [MSHR_BUFFER_LEN-1:0]    open;
    logic [MSHR_BUFFER_LEN-2:0]    vacate;
    logic                          primary;

    // Candidate entry built from the incoming miss
    always_comb begin
        blk = addr;
        blk.fields.block_offset = '0;
        blk.fields.byte_offset = '0;

        new_entry = '0;
        new_entry.valid = miss;
        new_entry.uuid = uuid;
        new_entry.block_addr = blk.word;
        new_entry.write_status[addr.fields.block_offset] = rw_mode;
        if (rw_mode) begin
            new_entry.write_block[addr.fields.block_offset] = store_value;
        end
    end

    // Secondary miss merge into any slot below the head
    always_comb begin
        merged = buffer;
        hit = '0;
        for (int i = 0; i < HEAD; i++) begin
            if (miss && buffer[i].valid && buffer[i].block_addr == new_entry.block_addr) begin
                hit[i] = 1'b1;
                merged[i].write_status = buffer[i].write_status | new_entry.write_status;
                if (rw_mode) begin
                    merged[i].write_block[addr.fields.block_offset] = store_value;
                end
            end
        end
    end

    // A slot is open when empty or when the whole queue advances
    always_comb begin
        for (int i = 0; i < MSHR_BUFFER_LEN; i++) begin
            open[i] = !buffer[i].valid || bank_empty;
        end
        for (int i = 0; i < HEAD; i++) begin
            vacate[i] = open[i+1];
        end
    end

    always_comb begin
        primary = miss && (hit == '0);
        stall = primary && !open[0];

        if (open[0]) begin
            next_buffer[0] = primary ? new_entry : '0;
        end else if (vacate[0]) begin
            next_buffer[0] = '0;
        end else begin
            next_buffer[0] = merged[0];
        end

        for (int i = 1; i < HEAD; i++) begin
            if (open[i]) begin
                next_buffer[i] = merged[i-1];
            end else if (vacate[i]) begin
                next_buffer[i] = '0;
            end else begin
                next_buffer[i] = merged[i];
            end
        end

        // Head leaves only into the bank
        if (open[HEAD]) begin
            next_buffer[HEAD] = merged[HEAD-1];
        end else begin
            next_buffer[HEAD] = merged[HEAD];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            buffer <= '0;
        end else begin
            buffer <= next_buffer;
        end
    end

    assign head_valid        = buffer[HEAD].valid;
    assign head_uuid         = buffer[HEAD].uuid;
    assign head_block_addr   = buffer[HEAD].block_addr;
    assign head_write_status = buffer[HEAD].write_status;
    assign head_write_block  = buffer[HEAD].write_block;

endmodule

/* design/miss_fill_bank.sv */
`timescale 1ns/1ns

module miss_fill_bank import cache_params_pkg::*, cache_types_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   head_valid,
    input  logic [UUID_W-1:0]                      head_uuid,
    input  logic [ADDR_W-1:0]                      head_block_addr,
    input  logic [WORDS_PER_BLOCK-1:0]             head_write_status,
    input  logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] head_write_block,
    output logic                                   bank_empty,
    output logic [BLOCK_ADDR_W-1:0]                rd_block_addr,
    input  logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] rd_block,
    output logic                                   wr_en,
    output logic [BLOCK_ADDR_W-1:0]                wr_block_addr,
    output logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] wr_block,
    output logic                                   fill_valid,
    output logic [UUID_W-1:0]                      fill_uuid,
    output logic [ADDR_W-1:0]                      fill_block_addr,
    output logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] fill_block
);

    mshr_reg                                entry;
    logic [FILL_CNT_W-1:0]                  count;
    logic                                   last;
    cache_addr_u                            blk;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] merged_block;

    // Entry valid doubles as the busy flag
    assign bank_empty = !entry.valid;
    assign last       = entry.valid && (count == '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entry <= '0;
            count <= '0;
        end else if (bank_empty) begin
            if (head_valid) begin
                entry.valid        <= 1'b1;
                entry.uuid         <= head_uuid;
                entry.block_addr   <= head_block_addr;
                entry.write_status <= head_write_status;
                entry.write_block  <= head_write_block;
                count              <= FILL_CNT_W'(FILL_LATENCY - 1);
            end
        end else if (last) begin
            entry.valid <= 1'b0;
        end else begin
            count <= count - 1'b1;
        end
    end

    // Block number from the held address
    always_comb begin
        blk.word = entry.block_addr;
        rd_block_addr = {blk.fields.tag, blk.fields.index};
    end

    // Stored words override the fetched ones
    always_comb begin
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            if (entry.write_status[w]) begin
                merged_block[w] = entry.write_block[w];
            end else begin
                merged_block[w] = rd_block[w];
            end
        end
    end

    assign wr_en         = last;
    assign wr_block_addr = rd_block_addr;
    assign wr_block      = merged_block;

    assign fill_valid      = last;
    assign fill_uuid       = entry.uuid;
    assign fill_block_addr = entry.block_addr;
    assign fill_block      = merged_block;

endmodule

/* design/cache_miss_unit.sv */
`timescale 1ns/1ns

module cache_miss_unit import cache_params_pkg::*, cache_types_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   miss,
    input  logic [UUID_W-1:0]                      uuid,
    input  cache_addr_u                            addr,
    input  logic                                   rw_mode,
    input  logic [WORD_W-1:0]                      store_value,
    output logic                                   stall,
    output logic                                   fill_valid,
    output logic [UUID_W-1:0]                      fill_uuid,
    output logic [ADDR_W-1:0]                      fill_block_addr,
    output logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] fill_block
);

    logic                                   bank_empty;
    logic                                   head_valid;
    logic [UUID_W-1:0]                      head_uuid;
    logic [ADDR_W-1:0]                      head_block_addr;
    logic [WORDS_PER_BLOCK-1:0]             head_write_status;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] head_write_block;

    logic [BLOCK_ADDR_W-1:0]                rd_block_addr;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] rd_block;
    logic                                   wr_en;
    logic [BLOCK_ADDR_W-1:0]                wr_block_addr;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] wr_block;

    cache_mshr_buffer buffer_i (
        .CLK               (CLK),
        .nRST              (nRST),
        .miss              (miss),
        .uuid              (uuid),
        .addr              (addr),
        .rw_mode           (rw_mode),
        .store_value       (store_value),
        .bank_empty        (bank_empty),
        .stall             (stall),
        .head_valid        (head_valid),
        .head_uuid         (head_uuid),
        .head_block_addr   (head_block_addr),
        .head_write_status (head_write_status),
        .head_write_block  (head_write_block)
    );

    miss_fill_bank bank_i (
        .CLK               (CLK),
        .nRST              (nRST),
        .head_valid        (head_valid),
        .head_uuid         (head_uuid),
        .head_block_addr   (head_block_addr),
        .head_write_status (head_write_status),
        .head_write_block  (head_write_block),
        .bank_empty        (bank_empty),
        .rd_block_addr     (rd_block_addr),
        .rd_block          (rd_block),
        .wr_en             (wr_en),
        .wr_block_addr     (wr_block_addr),
        .wr_block          (wr_block),
        .fill_valid        (fill_valid),
        .fill_uuid         (fill_uuid),
        .fill_block_addr   (fill_block_addr),
        .fill_block        (fill_block)
    );

    backing_store store_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .rd_block_addr (rd_block_addr),
        .rd_block      (rd_block),
        .wr_en         (wr_en),
        .wr_block_addr (wr_block_addr),
        .wr_block      (wr_block)
    );

endmodule

/* verification/cache_miss_unit_tb.sv */
`timescale 1ns/1ns

module cache_miss_unit_tb import cache_params_pkg::*, cache_types_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_MISSES  = 200;
    localparam int TOTAL_MISSES   = RANDOM_MISSES + 12;
    localparam int TIMEOUT_CYCLES =
        TOTAL_MISSES * (FILL_LATENCY + MSHR_BUFFER_LEN + 4) + RESET_CYCLES;
    localparam int BLOCK_BITS     = WORDS_PER_BLOCK * WORD_W;

    typedef logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] block_t;

    // One accepted primary miss with the stores folded into it
    typedef struct {
        logic [UUID_W-1:0]          uuid;
        logic [BLOCK_ADDR_W-1:0]    block;
        logic [WORDS_PER_BLOCK-1:0] mask;
        block_t                     data;
        int                         accept_cycle;
    } pending_t;

    logic              CLK;
    logic              nRST;
    logic              miss;
    logic [UUID_W-1:0] uuid;
    cache_addr_u       addr;
    logic              rw_mode;
    logic [WORD_W-1:0] store_value;
    logic              stall;
    logic              fill_valid;
    logic [UUID_W-1:0] fill_uuid;
    logic [ADDR_W-1:0] fill_block_addr;
    block_t            fill_block;

    pending_t          pending[$];
    block_t            mirror [NUM_BLOCKS];
    logic              block_busy [NUM_BLOCKS];
    logic [31:0]       seed = 32'h9866b52c;
    logic [UUID_W-1:0] next_uuid;
    logic [UUID_W-1:0] last_fill_uuid;
    block_t            last_fill_block;
    int                cycle;
    int                fills_seen;
    int                last_latency;

    cache_miss_unit dut_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .miss            (miss),
        .uuid            (uuid),
        .addr            (addr),
        .rw_mode         (rw_mode),
        .store_value     (store_value),
        .stall           (stall),
        .fill_valid      (fill_valid),
        .fill_uuid       (fill_uuid),
        .fill_block_addr (fill_block_addr),
        .fill_block      (fill_block)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Run timed out waiting for fills");
        $display("SOME TESTS FAILED");
        $fatal;
    end

    task automatic check_equal(input logic [BLOCK_BITS-1:0] actual,
                               input logic [BLOCK_BITS-1:0] expected, input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal;
        end
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic cache_addr_u make_addr(input logic [BLOCK_ADDR_W-1:0] blk,
                                              input logic [BLOCK_OFF_BIT_LEN-1:0] word,
                                              input logic [BYTE_OFF_BIT_LEN-1:0] byte_off);
        cache_addr_u a;
        a.fields.tag          = blk[BLOCK_ADDR_W-1:INDEX_BIT_LEN];
        a.fields.index        = blk[INDEX_BIT_LEN-1:0];
        a.fields.block_offset = word;
        a.fields.byte_offset  = byte_off;
        return a;
    endfunction

    // A miss to a block still waiting folds into that entry
    task automatic model_accept(input logic [UUID_W-1:0] id, input logic [BLOCK_ADDR_W-1:0] blk,
                                input logic [BLOCK_OFF_BIT_LEN-1:0] word, input logic is_store,
                                input logic [WORD_W-1:0] value);
        pending_t ent;
        int       hit;
        hit = -1;
        for (int i = 0; i < pending.size(); i++) begin
            if (pending[i].block == blk) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            ent = pending[hit];
        end else begin
            ent.uuid         = id;
            ent.block        = blk;
            ent.mask         = '0;
            ent.data         = '0;
            ent.accept_cycle = cycle;
        end
        if (is_store) begin
            ent.mask[word] = 1'b1;
            ent.data[word] = value;
        end
        if (hit >= 0) begin
            pending[hit] = ent;
        end else begin
            pending.push_back(ent);
            block_busy[blk] = 1'b1;
        end
    endtask

    // Drives one miss and holds it until stall drops
    task automatic send_miss(input logic [BLOCK_ADDR_W-1:0] blk,
                             input logic [BLOCK_OFF_BIT_LEN-1:0] word, input logic is_store,
                             input logic [WORD_W-1:0] value, output int stalls);
        logic [UUID_W-1:0] id;
        logic [31:0]       r;
        id = next_uuid;
        next_uuid = next_uuid + 1'b1;
        r = lcg_next();
        stalls = 0;
        @(posedge CLK);
        miss        <= 1'b1;
        uuid        <= id;
        addr        <= make_addr(blk, word, r[1:0]);
        rw_mode     <= is_store;
        store_value <= value;
        @(negedge CLK);
        while (stall) begin
            stalls++;
            @(negedge CLK);
        end
        model_accept(id, blk, word, is_store, value);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            miss    <= 1'b0;
            rw_mode <= 1'b0;
        end
    endtask

    task automatic drain();
        while (pending.size() != 0) @(posedge CLK);
    endtask

    always @(negedge CLK) begin : fill_monitor
        pending_t    ent;
        block_t      expected;
        cache_addr_u exp_addr;
        if (nRST && fill_valid) begin
            if (pending.size() == 0) begin
                $display("Fill for uuid %0h arrived with no outstanding miss", fill_uuid);
                $display("SOME TESTS FAILED");
                $fatal;
            end else begin
                ent = pending.pop_front();
                expected = mirror[ent.block];
                for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                    if (ent.mask[w]) begin
                        expected[w] = ent.data[w];
                    end
                end
                exp_addr = make_addr(ent.block, '0, '0);
                check_equal(BLOCK_BITS'(fill_uuid), BLOCK_BITS'(ent.uuid), "fill uuid");
                check_equal(BLOCK_BITS'(fill_block_addr), BLOCK_BITS'(exp_addr.word),
                            "fill block address");
                check_equal(fill_block, expected, "fill data");
                mirror[ent.block] = expected;
                block_busy[ent.block] = 1'b0;
                last_latency    = cycle - ent.accept_cycle;
                last_fill_uuid  = fill_uuid;
                last_fill_block = fill_block;
                fills_seen++;
            end
        end
    end

    initial begin
        int                      stalls;
        int                      fills_before;
        logic [UUID_W-1:0]       first_id;
        logic [31:0]             r;
        logic [BLOCK_ADDR_W-1:0] blk;
        nRST        = 1'b0;
        miss        = 1'b0;
        uuid        = '0;
        addr        = '0;
        rw_mode     = 1'b0;
        store_value = '0;
        next_uuid   = '0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            mirror[b]     = '0;
            block_busy[b] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        repeat (5) begin
            @(negedge CLK);
            check_equal(BLOCK_BITS'(stall), '0, "stall after reset");
            check_equal(BLOCK_BITS'(fill_valid), '0, "fill_valid after reset");
        end

        // Single load through an idle queue
        first_id = next_uuid;
        send_miss(8'h80, 2'd1, 1'b0, '0, stalls);
        idle(1);
        drain();
        idle(4);
        check_equal(BLOCK_BITS'(last_fill_uuid), BLOCK_BITS'(first_id), "single load uuid");
        check_equal(last_fill_block, '0, "single load data");
        check_equal(BLOCK_BITS'(last_latency), BLOCK_BITS'(FILL_LATENCY + MSHR_BUFFER_LEN),
                    "accept to fill cycles");

        // Store and then reload the same block
        send_miss(8'h81, 2'd2, 1'b1, 32'hA5A5_0F0F, stalls);
        idle(1);
        drain();
        send_miss(8'h81, 2'd0, 1'b0, '0, stalls);
        idle(1);
        drain();
        check_equal(BLOCK_BITS'(last_fill_block[2]), BLOCK_BITS'(32'hA5A5_0F0F), "reloaded word");

        // Two stores to one block merge while the bank is busy
        send_miss(8'h82, 2'd3, 1'b0, '0, stalls);
        idle(MSHR_BUFFER_LEN + 1);
        fills_before = fills_seen;
        first_id = next_uuid;
        send_miss(8'h83, 2'd0, 1'b1, 32'h1111_2222, stalls);
        send_miss(8'h83, 2'd3, 1'b1, 32'h3333_4444, stalls);
        check_equal(BLOCK_BITS'(stalls), '0, "stall on secondary miss");
        idle(1);
        drain();
        idle(4);
        check_equal(BLOCK_BITS'(fills_seen - fills_before), BLOCK_BITS'(2), "fills around merge");
        check_equal(BLOCK_BITS'(last_fill_uuid), BLOCK_BITS'(first_id), "merged fill uuid");
        check_equal(BLOCK_BITS'(last_fill_block[0]), BLOCK_BITS'(32'h1111_2222), "merged word 0");
        check_equal(BLOCK_BITS'(last_fill_block[3]), BLOCK_BITS'(32'h3333_4444), "merged word 3");

        // Overfill the queue behind a busy bank
        send_miss(8'h84, 2'd0, 1'b0, '0, stalls);
        idle(MSHR_BUFFER_LEN + 1);
        for (int i = 0; i <= MSHR_BUFFER_LEN; i++) begin
            send_miss(BLOCK_ADDR_W'(8'h90 + i), 2'(i), 1'b1, lcg_next(), stalls);
        end
        check_equal(BLOCK_BITS'(stalls != 0), BLOCK_BITS'(1), "stall on last queued miss");
        idle(1);
        drain();

        // Random loads and stores over a small block range
        for (int n = 0; n < RANDOM_MISSES; n++) begin
            r = lcg_next();
            blk = BLOCK_ADDR_W'(r % 24);
            while (block_busy[blk]) begin
                r = lcg_next();
                blk = BLOCK_ADDR_W'(r % 24);
            end
            send_miss(blk, r[9:8], r[10], lcg_next(), stalls);
            idle(int'(r[12:11]));
        end
        idle(1);
        drain();
        idle(4);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
design/cache_params_pkg.sv
design/cache_types_pkg.sv
design/backing_store.sv
design/cache_mshr_buffer.sv
design/miss_fill_bank.sv
design/cache_miss_unit.sv
verification/cache_miss_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache miss unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module cache_miss_unit_tb -f filelist.f \
    -Mdir obj_dir -o cache_miss_unit_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/cache_miss_unit_sim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
